/* verilog/imager_pkg.sv */
package imager_pkg;

   // Stream widths.
   localparam int PIXEL_WIDTH = 10;
   localparam int OUT_WIDTH = 12;
   localparam int GAIN_WIDTH = 8;
   localparam int GAIN_FRAC_BITS = 4;
   localparam int DTYPE_WIDTH = 2;

   // Register bus widths.
   localparam int TERM_WIDTH = 8;
   localparam int REG_WIDTH = 8;
   localparam int DATA_WIDTH = 16;

   typedef enum logic [DTYPE_WIDTH-1:0] {
      DT_FRAME_START = 2'd0,
      DT_LINE_START = 2'd1,
      DT_PIXEL = 2'd2,
      DT_FRAME_END = 2'd3
   } dtype_t;

   // Tag sits in the top bits of every beat.
   typedef struct packed {
      dtype_t dtype;
      logic [PIXEL_WIDTH-1:0] pixel;
   } in_beat_t;

   typedef struct packed {
      dtype_t dtype;
      logic [OUT_WIDTH-1:0] data;
   } out_beat_t;

   // Terminal numbers.
   localparam logic [TERM_WIDTH-1:0] TERM_CONTROL = 8'd1;
   localparam logic [TERM_WIDTH-1:0] TERM_CAPTURE_IN = 8'd2;
   localparam logic [TERM_WIDTH-1:0] TERM_CAPTURE_OUT = 8'd3;

   // Control terminal registers.
   localparam logic [REG_WIDTH-1:0] REG_CTRL = 8'd0;
   localparam logic [REG_WIDTH-1:0] REG_GAIN = 8'd1;
   localparam logic [REG_WIDTH-1:0] REG_ID = 8'd2;

   // Capture terminal registers.
   localparam logic [REG_WIDTH-1:0] REG_CAP_DATA = 8'd0;
   localparam logic [REG_WIDTH-1:0] REG_CAP_STATUS = 8'd1;

   localparam logic [DATA_WIDTH-1:0] HUB_ID = 16'h1a51;

   // REG_CTRL bits.
   localparam int CTRL_GAIN_SEL = 0;
   localparam int CTRL_CAP_EN = 1;
   localparam int CTRL_CAP_PIX_IN = 2;
   localparam int CTRL_CAP_PIX_OUT = 3;

endpackage

/* verilog/reg_bus_if.sv */
interface reg_bus_if import imager_pkg::*; ();

   logic write;
   logic read;
   logic [REG_WIDTH-1:0] reg_addr;
   logic [DATA_WIDTH-1:0] wdata;
   // Combinational read data from the terminal.
   logic [DATA_WIDTH-1:0] rdata;

   modport decoder (
      output write,
      output read,
      output reg_addr,
      output wdata,
      input rdata
   );

   modport terminal (
      input write,
      input read,
      input reg_addr,
      input wdata,
      output rdata
   );

endinterface

/* verilog/stream_if.sv */
interface stream_if #(
   parameter type beat_t = logic
) ();

   logic valid;
   logic ready;
   beat_t beat;

   modport source (
      output valid,
      output beat,
      input ready
   );

   modport sink (
      input valid,
      input beat,
      output ready
   );

   // Passive observer of the handshake.
   modport tap (
      input valid,
      input ready,
      input beat
   );

endinterface

/* verilog/host_decoder.sv */
module host_decoder import imager_pkg::*; (
   input logic clk,
   input logic resetb,
   input logic [TERM_WIDTH-1:0] term,
   input logic [REG_WIDTH-1:0] reg_addr,
   input logic [DATA_WIDTH-1:0] wdata,
   input logic write,
   input logic read,
   output logic [DATA_WIDTH-1:0] rdata,
   output logic rvalid,
   output logic err,
   reg_bus_if.decoder ctrl_bus,
   reg_bus_if.decoder cap_in_bus,
   reg_bus_if.decoder cap_out_bus
);

   logic hit_ctrl;
   logic hit_cap_in;
   logic hit_cap_out;
   logic hit_any;
   logic [DATA_WIDTH-1:0] sel_rdata;

   assign hit_ctrl = (term == TERM_CONTROL);
   assign hit_cap_in = (term == TERM_CAPTURE_IN);
   assign hit_cap_out = (term == TERM_CAPTURE_OUT);
   assign hit_any = hit_ctrl | hit_cap_in | hit_cap_out;

   // Strobes go only to the addressed terminal.
   assign ctrl_bus.write = write & hit_ctrl;
   assign ctrl_bus.read = read & hit_ctrl;
   assign ctrl_bus.reg_addr = reg_addr;
   assign ctrl_bus.wdata = wdata;

   assign cap_in_bus.write = write & hit_cap_in;
   assign cap_in_bus.read = read & hit_cap_in;
   assign cap_in_bus.reg_addr = reg_addr;
   assign cap_in_bus.wdata = wdata;

   assign cap_out_bus.write = write & hit_cap_out;
   assign cap_out_bus.read = read & hit_cap_out;
   assign cap_out_bus.reg_addr = reg_addr;
   assign cap_out_bus.wdata = wdata;

   // Unknown terminals read as zero.
   always_comb begin
      sel_rdata = '0;
      if (hit_ctrl) begin
         sel_rdata = ctrl_bus.rdata;
      end else if (hit_cap_in) begin
         sel_rdata = cap_in_bus.rdata;
      end else if (hit_cap_out) begin
         sel_rdata = cap_out_bus.rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         rvalid <= 1'b0;
         err <= 1'b0;
      end else begin
         rvalid <= read;
         err <= read & ~hit_any;
      end
   end

   // Answer data, held until the next read.
   always_ff @(posedge clk) begin
      if (read) begin
         rdata <= sel_rdata;
      end
   end

endmodule

/* verilog/control_terminal.sv */
module control_terminal import imager_pkg::*; (
   input logic clk,
   input logic resetb,
   reg_bus_if.terminal bus,
   output logic gain_sel,
   output logic cap_en,
   output logic cap_pix_in,
   output logic cap_pix_out,
   output logic [GAIN_WIDTH-1:0] gain
);

   logic [CTRL_CAP_PIX_OUT:0] ctrl_reg;
   logic [GAIN_WIDTH-1:0] gain_reg;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         ctrl_reg <= '0;
         gain_reg <= '0;
      end else if (bus.write) begin
         if (bus.reg_addr == REG_CTRL) begin
            ctrl_reg <= bus.wdata[CTRL_CAP_PIX_OUT:0];
         end
         if (bus.reg_addr == REG_GAIN) begin
            gain_reg <= bus.wdata[GAIN_WIDTH-1:0];
         end
      end
   end

   // Readback, unused addresses give zero.
   always_comb begin
      case (bus.reg_addr)
         REG_CTRL: begin
            bus.rdata = DATA_WIDTH'(ctrl_reg);
         end
         REG_GAIN: begin
            bus.rdata = DATA_WIDTH'(gain_reg);
         end
         REG_ID: begin
            bus.rdata = HUB_ID;
         end
         default: begin
            bus.rdata = '0;
         end
      endcase
   end

   assign gain_sel = ctrl_reg[CTRL_GAIN_SEL];
   assign cap_en = ctrl_reg[CTRL_CAP_EN];
   assign cap_pix_in = ctrl_reg[CTRL_CAP_PIX_IN];
   assign cap_pix_out = ctrl_reg[CTRL_CAP_PIX_OUT];
   assign gain = gain_reg;

endmodule

/* verilog/gain_stage.sv */
module gain_stage import imager_pkg::*; (
   input logic clk,
   input logic resetb,
   input logic gain_sel,
   input logic [GAIN_WIDTH-1:0] gain,
   stream_if.sink in_stream,
   stream_if.source out_stream
);

   localparam int PROD_WIDTH = PIXEL_WIDTH + GAIN_WIDTH;
   localparam int SHIFT_WIDTH = PROD_WIDTH - GAIN_FRAC_BITS;

   logic advance;
   logic s1_valid;
   logic s1_scale;
   in_beat_t s1_beat;
   logic [PROD_WIDTH-1:0] s1_prod;
   logic [SHIFT_WIDTH-1:0] shifted;
   logic [OUT_WIDTH-1:0] scaled;
   logic [OUT_WIDTH-1:0] s2_data;
   logic s2_valid;
   out_beat_t s2_beat;

   // Whole pipe moves when the output slot frees up.
   assign advance = ~s2_valid | out_stream.ready;
   assign in_stream.ready = advance;

   always_ff @(posedge clk) begin
      if (!resetb) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else if (advance) begin
         s1_valid <= in_stream.valid;
         s2_valid <= s1_valid;
      end
   end

   // Stage one, product and mode latched on entry.
   always_ff @(posedge clk) begin
      if (advance) begin
         s1_beat <= in_stream.beat;
         s1_prod <= in_stream.beat.pixel * gain;
         s1_scale <= gain_sel & (in_stream.beat.dtype == DT_PIXEL);
      end
   end

   // Drop fraction, clamp to all ones.
   assign shifted = s1_prod[PROD_WIDTH-1:GAIN_FRAC_BITS];
   assign scaled = (|shifted[SHIFT_WIDTH-1:OUT_WIDTH]) ? '1 : shifted[OUT_WIDTH-1:0];
   assign s2_data = s1_scale ? scaled : OUT_WIDTH'(s1_beat.pixel);

   always_ff @(posedge clk) begin
      if (advance) begin
         s2_beat.dtype <= s1_beat.dtype;
         s2_beat.data <= s2_data;
      end
   end

   assign out_stream.valid = s2_valid;
   assign out_stream.beat = s2_beat;

endmodule

/* verilog/stream_capture.sv */
module stream_capture import imager_pkg::*; #(
   parameter type beat_t = in_beat_t,
   parameter int CAPTURE_DEPTH = 16
) (
   input logic clk,
   input logic resetb,
   stream_if.tap tap,
   input logic enable,
   input logic pix_only,
   reg_bus_if.terminal bus
);

   localparam int ADDR_WIDTH = $clog2(CAPTURE_DEPTH);
   localparam int BEAT_WIDTH = $bits(beat_t);
   localparam int PAYLOAD_WIDTH = BEAT_WIDTH - DTYPE_WIDTH;

   beat_t mem [CAPTURE_DEPTH];
   logic [ADDR_WIDTH-1:0] wr_ptr;
   logic [ADDR_WIDTH-1:0] rd_ptr;
   logic [ADDR_WIDTH:0] count;
   logic overflow;
   logic full;
   logic empty;
   logic push_req;
   logic push;
   logic pop;
   logic status_rd;
   logic [BEAT_WIDTH-1:0] head;
   logic [DATA_WIDTH-1:0] head_word;
   logic [DATA_WIDTH-1:0] status_word;

   assign full = (count == (ADDR_WIDTH+1)'(CAPTURE_DEPTH));
   assign empty = (count == '0);

   // Tap never stalls the stream.
   assign push_req = enable & tap.valid & tap.ready & (~pix_only | (tap.beat.dtype == DT_PIXEL));
   assign push = push_req & ~full;
   assign pop = bus.read & (bus.reg_addr == REG_CAP_DATA) & ~empty;
   assign status_rd = bus.read & (bus.reg_addr == REG_CAP_STATUS);

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= tap.beat;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetb) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         overflow <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + push - pop;
         // A new drop wins over the clearing read.
         if (push_req & full) begin
            overflow <= 1'b1;
         end else if (status_rd) begin
            overflow <= 1'b0;
         end
      end
   end

   // Dtype moves to the top of the word.
   assign head = mem[rd_ptr];
   assign head_word = {head[BEAT_WIDTH-1 -: DTYPE_WIDTH],
                       (DATA_WIDTH-DTYPE_WIDTH)'(head[PAYLOAD_WIDTH-1:0])};

   always_comb begin
      status_word = '0;
      status_word[ADDR_WIDTH:0] = count;
      status_word[DATA_WIDTH-1] = overflow;
   end

   always_comb begin
      case (bus.reg_addr)
         REG_CAP_DATA: begin
            bus.rdata = empty ? '0 : head_word;
         end
         REG_CAP_STATUS: begin
            bus.rdata = status_word;
         end
         default: begin
            bus.rdata = '0;
         end
      endcase
   end

endmodule

/* verilog/imager_hub.sv */
module imager_hub import imager_pkg::*; #(
   parameter int CAPTURE_DEPTH = 16
) (
   input logic clk,
   input logic resetb,
   input logic pix_valid,
   output logic pix_ready,
   input logic [DTYPE_WIDTH-1:0] pix_dtype,
   input logic [PIXEL_WIDTH-1:0] pix_data,
   output logic out_valid,
   input logic out_ready,
   output logic [DTYPE_WIDTH-1:0] out_dtype,
   output logic [OUT_WIDTH-1:0] out_data,
   input logic [TERM_WIDTH-1:0] host_term,
   input logic [REG_WIDTH-1:0] host_reg,
   input logic [DATA_WIDTH-1:0] host_wdata,
   input logic host_write,
   input logic host_read,
   output logic [DATA_WIDTH-1:0] host_rdata,
   output logic host_rvalid,
   output logic host_err
);

   logic gain_sel;
   logic cap_en;
   logic cap_pix_in;
   logic cap_pix_out;
   logic [GAIN_WIDTH-1:0] gain;

   stream_if #(.beat_t(in_beat_t)) in_stream ();
   stream_if #(.beat_t(out_beat_t)) out_stream ();

   reg_bus_if ctrl_bus ();
   reg_bus_if cap_in_bus ();
   reg_bus_if cap_out_bus ();

   // Plain ports onto the stream interfaces.
   assign in_stream.valid = pix_valid;
   assign in_stream.beat = '{dtype: dtype_t'(pix_dtype), pixel: pix_data};
   assign pix_ready = in_stream.ready;

   assign out_valid = out_stream.valid;
   assign out_stream.ready = out_ready;
   assign out_dtype = out_stream.beat.dtype;
   assign out_data = out_stream.beat.data;

   host_decoder host_decoder0 (
      .clk(clk),
      .resetb(resetb),
      .term(host_term),
      .reg_addr(host_reg),
      .wdata(host_wdata),
      .write(host_write),
      .read(host_read),
      .rdata(host_rdata),
      .rvalid(host_rvalid),
      .err(host_err),
      .ctrl_bus(ctrl_bus),
      .cap_in_bus(cap_in_bus),
      .cap_out_bus(cap_out_bus)
   );

   control_terminal control0 (
      .clk(clk),
      .resetb(resetb),
      .bus(ctrl_bus),
      .gain_sel(gain_sel),
      .cap_en(cap_en),
      .cap_pix_in(cap_pix_in),
      .cap_pix_out(cap_pix_out),
      .gain(gain)
   );

   gain_stage gain0 (
      .clk(clk),
      .resetb(resetb),
      .gain_sel(gain_sel),
      .gain(gain),
      .in_stream(in_stream),
      .out_stream(out_stream)
   );

   stream_capture #(.beat_t(in_beat_t), .CAPTURE_DEPTH(CAPTURE_DEPTH)) cap_in (
      .clk(clk),
      .resetb(resetb),
      .tap(in_stream),
      .enable(cap_en),
      .pix_only(cap_pix_in),
      .bus(cap_in_bus)
   );

   stream_capture #(.beat_t(out_beat_t), .CAPTURE_DEPTH(CAPTURE_DEPTH)) cap_out (
      .clk(clk),
      .resetb(resetb),
      .tap(out_stream),
      .enable(cap_en),
      .pix_only(cap_pix_out),
      .bus(cap_out_bus)
   );

endmodule

/* tests/imager_hub_chk.sv */
module imager_hub_chk import imager_pkg::*; (
   input logic clk,
   input logic resetb,
   input logic out_valid,
   input logic out_ready,
   input logic [DTYPE_WIDTH-1:0] out_dtype,
   input logic [OUT_WIDTH-1:0] out_data,
   input logic host_read,
   input logic host_rvalid
);

   // A stalled output beat must not change.
   a_out_hold: assert property (@(posedge clk) disable iff (!resetb)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_dtype) && $stable(out_data)))
      else $error("output beat changed while stalled");

   // Read answer one cycle after the request.
   a_rvalid_after_read: assert property (@(posedge clk) disable iff (!resetb)
      host_read |=> host_rvalid)
      else $error("host_rvalid missing one cycle after host_read");

   a_rvalid_only_after_read: assert property (@(posedge clk) disable iff (!resetb)
      !host_read |=> !host_rvalid)
      else $error("host_rvalid without a preceding host_read");

   a_reset_idle: assert property (@(posedge clk) !resetb |=> !out_valid)
      else $error("out_valid high after reset");

endmodule

bind imager_hub imager_hub_chk chk0 (.*);

/* tests/imager_hub_tb.sv */
module imager_hub_tb import imager_pkg::*; ();

   localparam int DEPTH = 16;
   // Beats per frame are 2 + lines * (pixels per line + 1).
   localparam int TOTAL_BEATS = (2 + 4 * 9) + 2 * (2 + 3 * 9) + (2 + 6 * 11)
                                + (2 + 2 * 5) + (2 + 3 * 6);
   localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 500;

   logic clk;
   logic resetb;
   logic pix_valid;
   logic pix_ready;
   logic [DTYPE_WIDTH-1:0] pix_dtype;
   logic [PIXEL_WIDTH-1:0] pix_data;
   logic out_valid;
   logic out_ready;
   logic [DTYPE_WIDTH-1:0] out_dtype;
   logic [OUT_WIDTH-1:0] out_data;
   logic [TERM_WIDTH-1:0] host_term;
   logic [REG_WIDTH-1:0] host_reg;
   logic [DATA_WIDTH-1:0] host_wdata;
   logic host_write;
   logic host_read;
   logic [DATA_WIDTH-1:0] host_rdata;
   logic host_rvalid;
   logic host_err;

   int errors;
   int beats_taken;
   bit stream_done;
   in_beat_t stim_q[$];
   out_beat_t exp_q[$];
   in_beat_t saved_in[$];
   out_beat_t saved_out[$];
   int cap_q[$];

   imager_hub #(.CAPTURE_DEPTH(DEPTH)) dut0 (.*);

   always #5 clk = ~clk;

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
      end
   endtask

   // Output pixel from the gain rule.
   function automatic int scale_pixel(input dtype_t dt, input int pixel, input bit sel,
                                      input int g);
      int v;
      if (!sel || dt != DT_PIXEL) begin
         return pixel;
      end
      v = (pixel * g) >> GAIN_FRAC_BITS;
      return (v > (1 << OUT_WIDTH) - 1) ? (1 << OUT_WIDTH) - 1 : v;
   endfunction

   function automatic int in_word(input in_beat_t b);
      return (int'(b.dtype) << (DATA_WIDTH - DTYPE_WIDTH)) | int'(b.pixel);
   endfunction

   function automatic int out_word(input out_beat_t b);
      return (int'(b.dtype) << (DATA_WIDTH - DTYPE_WIDTH)) | int'(b.data);
   endfunction

   task automatic push_beat(input dtype_t dt, input bit sel, input int g);
      in_beat_t b;
      out_beat_t e;
      b.dtype = dt;
      b.pixel = PIXEL_WIDTH'($urandom);
      e.dtype = dt;
      e.data = OUT_WIDTH'(scale_pixel(dt, int'(b.pixel), sel, g));
      stim_q.push_back(b);
      exp_q.push_back(e);
   endtask

   task automatic build_frame(input int lines, input int ppl, input bit sel, input int g);
      push_beat(DT_FRAME_START, sel, g);
      for (int l = 0; l < lines; l++) begin
         push_beat(DT_LINE_START, sel, g);
         for (int p = 0; p < ppl; p++) begin
            push_beat(DT_PIXEL, sel, g);
         end
      end
      push_beat(DT_FRAME_END, sel, g);
   endtask

   task automatic reg_write(input logic [TERM_WIDTH-1:0] term, input logic [REG_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data);
      @(posedge clk);
      #1;
      host_term = term;
      host_reg = addr;
      host_wdata = data;
      host_write = 1'b1;
      @(posedge clk);
      #1;
      host_write = 1'b0;
   endtask

   task automatic reg_read(input logic [TERM_WIDTH-1:0] term, input logic [REG_WIDTH-1:0] addr,
                           output logic [DATA_WIDTH-1:0] data, output logic err);
      @(posedge clk);
      #1;
      host_term = term;
      host_reg = addr;
      host_read = 1'b1;
      @(posedge clk);
      #1;
      host_read = 1'b0;
      @(negedge clk);
      check_value(host_rvalid, 1'b1, "host_rvalid one cycle after read");
      data = host_rdata;
      err = host_err;
   endtask

   task automatic drive_beats();
      in_beat_t b;
      @(posedge clk);
      #1;
      while (stim_q.size() > 0) begin
         b = stim_q.pop_front();
         pix_valid = 1'b1;
         pix_dtype = b.dtype;
         pix_data = b.pixel;
         @(negedge clk);
         while (!pix_ready) begin
            @(negedge clk);
         end
         @(posedge clk);
         beats_taken++;
         #1;
      end
      pix_valid = 1'b0;
   endtask

   task automatic monitor_beats(input int n);
      out_beat_t e;
      int got;
      got = 0;
      while (got < n) begin
         @(negedge clk);
         if (out_valid && out_ready) begin
            e = exp_q.pop_front();
            check_value(out_dtype, e.dtype, $sformatf("beat %0d dtype", got));
            check_value(out_data, e.data, $sformatf("beat %0d data", got));
            got++;
         end
      end
   endtask

   task automatic run_stream(input bit toggle_ready);
      int n;
      n = stim_q.size();
      stream_done = 1'b0;
      beats_taken = 0;
      fork
         drive_beats();
         begin
            monitor_beats(n);
            stream_done = 1'b1;
         end
         begin
            if (toggle_ready) begin
               // Output held off until the pipe has filled.
               out_ready = 1'b0;
               repeat (6) @(negedge clk);
               check_value(beats_taken, 2, "beats taken while output stalled");
               check_value(pix_ready, 1'b0, "pix_ready with full pipe and output stalled");
            end
            while (!stream_done) begin
               @(posedge clk);
               #1;
               if (toggle_ready) begin
                  out_ready = $urandom_range(1, 0);
               end
            end
         end
      join
      out_ready = 1'b1;
      // Nothing may follow the last expected beat.
      repeat (4) begin
         @(negedge clk);
         check_value(out_valid, 1'b0, "extra output beat");
      end
   endtask

   task automatic read_capture(input logic [TERM_WIDTH-1:0] term, input string name);
      logic [DATA_WIDTH-1:0] d;
      logic e;
      while (cap_q.size() > 0) begin
         reg_read(term, REG_CAP_DATA, d, e);
         check_value(d, cap_q.pop_front(), {name, " capture data"});
      end
   endtask

   task automatic test_registers();
      logic [DATA_WIDTH-1:0] d;
      logic e;
      logic [GAIN_WIDTH-1:0] g;
      g = GAIN_WIDTH'($urandom_range(255, 1));
      reg_read(TERM_CONTROL, REG_CTRL, d, e);
      check_value(d, 0, "REG_CTRL after reset");
      check_value(e, 0, "host_err on control read");
      reg_read(TERM_CONTROL, REG_ID, d, e);
      check_value(d, HUB_ID, "REG_ID");
      reg_write(TERM_CONTROL, REG_GAIN, DATA_WIDTH'(g));
      reg_read(TERM_CONTROL, REG_GAIN, d, e);
      check_value(d, g, "REG_GAIN readback");
      reg_read(8'd9, REG_CTRL, d, e);
      check_value(d, 0, "unknown terminal data");
      check_value(e, 1, "unknown terminal host_err");
   endtask

   task automatic test_raw_stream();
      reg_write(TERM_CONTROL, REG_CTRL, 16'h0000);
      build_frame(4, 8, 1'b0, 0);
      run_stream(1'b0);
   endtask

   task automatic test_gain();
      int g;
      g = $urandom_range(255, 1);
      reg_write(TERM_CONTROL, REG_GAIN, DATA_WIDTH'(g));
      reg_write(TERM_CONTROL, REG_CTRL, 16'(1 << CTRL_GAIN_SEL));
      build_frame(3, 8, 1'b1, g);
      run_stream(1'b0);
      // Large gain drives most pixels into saturation.
      reg_write(TERM_CONTROL, REG_GAIN, 16'h00f0);
      build_frame(3, 8, 1'b1, 'hf0);
      run_stream(1'b0);
   endtask

   task automatic test_backpressure();
      int g;
      g = $urandom_range(255, 1);
      reg_write(TERM_CONTROL, REG_GAIN, DATA_WIDTH'(g));
      reg_write(TERM_CONTROL, REG_CTRL, 16'(1 << CTRL_GAIN_SEL));
      build_frame(6, 10, 1'b1, g);
      run_stream(1'b1);
   endtask

   task automatic test_capture();
      logic [DATA_WIDTH-1:0] d;
      logic e;
      reg_write(TERM_CONTROL, REG_CTRL, 16'((1 << CTRL_CAP_EN) | (1 << CTRL_CAP_PIX_IN)));
      build_frame(2, 4, 1'b0, 0);
      saved_in = stim_q;
      saved_out = exp_q;
      run_stream(1'b0);
      reg_write(TERM_CONTROL, REG_CTRL, 16'h0000);
      foreach (saved_in[i]) begin
         if (saved_in[i].dtype == DT_PIXEL) begin
            cap_q.push_back(in_word(saved_in[i]));
         end
      end
      reg_read(TERM_CAPTURE_IN, REG_CAP_STATUS, d, e);
      check_value(d, cap_q.size(), "input capture status");
      read_capture(TERM_CAPTURE_IN, "input");
      foreach (saved_out[i]) begin
         cap_q.push_back(out_word(saved_out[i]));
      end
      reg_read(TERM_CAPTURE_OUT, REG_CAP_STATUS, d, e);
      check_value(d, cap_q.size(), "output capture status");
      read_capture(TERM_CAPTURE_OUT, "output");
   endtask

   task automatic drain_full(input logic [TERM_WIDTH-1:0] term, input string name);
      logic [DATA_WIDTH-1:0] d;
      logic e;
      reg_read(term, REG_CAP_STATUS, d, e);
      check_value(d, (1 << 15) | DEPTH, {name, " status with overflow"});
      reg_read(term, REG_CAP_STATUS, d, e);
      check_value(d, DEPTH, {name, " status after overflow clear"});
      read_capture(term, name);
      reg_read(term, REG_CAP_DATA, d, e);
      check_value(d, 0, {name, " empty FIFO data"});
      reg_read(term, REG_CAP_STATUS, d, e);
      check_value(d, 0, {name, " status when empty"});
   endtask

   task automatic test_overflow();
      reg_write(TERM_CONTROL, REG_CTRL, 16'(1 << CTRL_CAP_EN));
      build_frame(3, 5, 1'b0, 0);
      saved_in = stim_q;
      saved_out = exp_q;
      run_stream(1'b0);
      reg_write(TERM_CONTROL, REG_CTRL, 16'h0000);
      // Only the first DEPTH beats were kept.
      for (int i = 0; i < DEPTH; i++) begin
         cap_q.push_back(in_word(saved_in[i]));
      end
      drain_full(TERM_CAPTURE_IN, "input");
      for (int i = 0; i < DEPTH; i++) begin
         cap_q.push_back(out_word(saved_out[i]));
      end
      drain_full(TERM_CAPTURE_OUT, "output");
   endtask

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      errors = 0;
      beats_taken = 0;
      void'($urandom(32'hff7a_4fb3));
      clk = 1'b0;
      resetb = 1'b0;
      pix_valid = 1'b0;
      pix_dtype = '0;
      pix_data = '0;
      out_ready = 1'b1;
      host_term = '0;
      host_reg = '0;
      host_wdata = '0;
      host_write = 1'b0;
      host_read = 1'b0;
      stream_done = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      resetb = 1'b1;
      check_value(out_valid, 1'b0, "out_valid after reset");
      check_value(pix_ready, 1'b1, "pix_ready after reset");
      check_value(host_rvalid, 1'b0, "host_rvalid after reset");
      check_value(host_err, 1'b0, "host_err after reset");
      test_registers();
      test_raw_stream();
      test_gain();
      test_backpressure();
      test_capture();
      test_overflow();
      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* project.f */
verilog/imager_pkg.sv
verilog/reg_bus_if.sv
verilog/stream_if.sv
verilog/host_decoder.sv
verilog/control_terminal.sv
verilog/gain_stage.sv
verilog/stream_capture.sv
verilog/imager_hub.sv
tests/imager_hub_chk.sv
tests/imager_hub_tb.sv

/* Bender.yml */
package:
  name: imager_hub

sources:
  - verilog/imager_pkg.sv
  - verilog/reg_bus_if.sv
  - verilog/stream_if.sv
  - verilog/host_decoder.sv
  - verilog/control_terminal.sv
  - verilog/gain_stage.sv
  - verilog/stream_capture.sv
  - verilog/imager_hub.sv
  - target: test
    files:
      - tests/imager_hub_chk.sv
      - tests/imager_hub_tb.sv
